/* Bender.yml */
package:
  name: shared_queue

dependencies: {}

sources:
  # packages first, the RTL reads them by scoped names
  - files:
      - common/shq_cfg_pkg.sv
      - common/shq_types_pkg.sv
  - files:
      - rtl/slot_index_fifo.sv
      - shared_queue/slot_allocator.sv
      - shared_queue/slot_memory.sv
      - shared_queue/shared_queue_top.sv
  - target: test
    files:
      - verification/shq_tb.sv

export_include_dirs: []

vendor_package: []

frozen: false

/* common/shq_cfg_pkg.sv */
package shq_cfg_pkg;

    // number of independent queues that share the pool.
    localparam int num_queues = 5;

    // slots in the shared pool. every queue can hold up to all of them.
    localparam int num_slots = 8;

    // width of one stored data word.
    localparam int data_width = 32;

    localparam int slot_width = $clog2(num_slots); // bits of a slot index.

    // the occupancy count has to reach num_slots itself, so one extra value.
    localparam int count_width = $clog2(num_slots + 1);

endpackage

/* common/shq_types_pkg.sv */
package shq_types_pkg;

    // one data word as written on din and read on dout.
    typedef logic [shq_cfg_pkg::data_width-1:0] data_t;

    typedef logic [shq_cfg_pkg::slot_width-1:0] slot_idx_t; // address of one pool slot.

    // one bit per queue, for the strobes and the level flags.
    typedef logic [shq_cfg_pkg::num_queues-1:0] queue_vec_t;

    // one bit per slot, set while the slot holds a live word.
    typedef logic [shq_cfg_pkg::num_slots-1:0] slot_map_t;

    typedef logic [shq_cfg_pkg::count_width-1:0] count_t; // occupied slots.

endpackage

/* compile.f */
common/shq_cfg_pkg.sv
common/shq_types_pkg.sv
rtl/slot_index_fifo.sv
shared_queue/slot_allocator.sv
shared_queue/slot_memory.sv
shared_queue/shared_queue_top.sv
verification/shq_tb.sv

/* rtl/slot_index_fifo.sv */
module slot_index_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     softreset,
    input  logic                     push,
    input  shq_types_pkg::slot_idx_t push_idx,
    input  logic                     pop,
    output shq_types_pkg::slot_idx_t head_idx,
    output logic                     empty
);

    shq_types_pkg::slot_idx_t entries [shq_cfg_pkg::num_slots];
    shq_types_pkg::slot_idx_t wr_ptr;
    shq_types_pkg::slot_idx_t rd_ptr;
    shq_types_pkg::count_t    used;

    // pointers wrap at num_slots, which need not be a power of two.
    function automatic shq_types_pkg::slot_idx_t next_ptr(
        input shq_types_pkg::slot_idx_t ptr
    );
        if (ptr == shq_types_pkg::slot_idx_t'(shq_cfg_pkg::num_slots - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else if (softreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                used <= used + 1'b1;
            end else if (pop && !push) begin
                used <= used - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_idx;
        end
    end

    assign head_idx = entries[rd_ptr]; // undefined while empty, never used then.
    assign empty    = (used == '0);

    // a queue never owns more slots than the pool has, so the allocator
    // cannot push into a full index FIFO.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> used != shq_types_pkg::count_t'(shq_cfg_pkg::num_slots));

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

/* shared_queue/shared_queue_top.sv */
module shared_queue_top (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              softreset,
    input  shq_types_pkg::queue_vec_t                         vldin,
    input  shq_types_pkg::data_t [shq_cfg_pkg::num_queues-1:0] din,
    input  shq_types_pkg::queue_vec_t                         readout,
    output shq_types_pkg::data_t [shq_cfg_pkg::num_queues-1:0] dout,
    output shq_types_pkg::queue_vec_t                         full,
    output shq_types_pkg::queue_vec_t                         empty,
    output shq_types_pkg::count_t                             count
);

    shq_types_pkg::queue_vec_t                             grant;
    shq_types_pkg::queue_vec_t                             pop;
    shq_types_pkg::slot_idx_t [shq_cfg_pkg::num_queues-1:0] alloc_idx;
    shq_types_pkg::slot_idx_t [shq_cfg_pkg::num_queues-1:0] head_idx;

    assign pop = readout & ~empty; // a read on an empty queue is dropped here.

    slot_allocator u_slot_allocator (
        .clk       (clk),
        .rst_n     (rst_n),
        .softreset (softreset),
        .vldin     (vldin),
        .pop       (pop),
        .head_idx  (head_idx),
        .grant     (grant),
        .alloc_idx (alloc_idx),
        .full      (full),
        .count     (count)
    );

    slot_memory u_slot_memory (
        .clk     (clk),
        .wr_en   (grant),
        .wr_idx  (alloc_idx),
        .wr_data (din),
        .rd_idx  (head_idx),
        .rd_data (dout)
    );

    // one index FIFO per queue keeps the order of the slots it was given.
    for (genvar q = 0; q < shq_cfg_pkg::num_queues; q++) begin : g_queue
        slot_index_fifo u_slot_index_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .softreset (softreset),
            .push      (grant[q]),
            .push_idx  (alloc_idx[q]),
            .pop       (pop[q]),
            .head_idx  (head_idx[q]),
            .empty     (empty[q])
        );
    end

endmodule

/* shared_queue/slot_allocator.sv */
module slot_allocator (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  softreset,
    input  shq_types_pkg::queue_vec_t                             vldin,
    input  shq_types_pkg::queue_vec_t                             pop,
    input  shq_types_pkg::slot_idx_t [shq_cfg_pkg::num_queues-1:0] head_idx,
    output shq_types_pkg::queue_vec_t                             grant,
    output shq_types_pkg::slot_idx_t [shq_cfg_pkg::num_queues-1:0] alloc_idx,
    output shq_types_pkg::queue_vec_t                             full,
    output shq_types_pkg::count_t                                 count
);

    shq_types_pkg::slot_map_t occupied;
    shq_types_pkg::slot_map_t next_map;
    shq_types_pkg::count_t    next_count;

    // queue 0 searches the bitmap first. every later queue sees the
    // slots already handed out to the queues before it in this cycle.
    always_comb begin
        shq_types_pkg::slot_map_t taken;
        taken = occupied;
        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            full[q]      = 1'b1;
            alloc_idx[q] = '0;
            for (int s = shq_cfg_pkg::num_slots - 1; s >= 0; s--) begin
                if (!taken[s]) begin
                    full[q]      = 1'b0; // the last hit is the lowest free slot.
                    alloc_idx[q] = shq_types_pkg::slot_idx_t'(s);
                end
            end
            grant[q] = vldin[q] & ~full[q];
            if (grant[q]) begin
                taken[alloc_idx[q]] = 1'b1;
            end
        end
        // freed slots only reach the search after the edge.
        next_map = taken;
        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            if (pop[q]) begin
                next_map[head_idx[q]] = 1'b0;
            end
        end
    end

    always_comb begin
        next_count = '0;
        for (int s = 0; s < shq_cfg_pkg::num_slots; s++) begin
            next_count = next_count + shq_types_pkg::count_t'(next_map[s]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
            count    <= '0;
        end else if (softreset) begin
            occupied <= '0;
            count    <= '0;
        end else begin
            occupied <= next_map;
            count    <= next_count;
        end
    end

    for (genvar q = 0; q < shq_cfg_pkg::num_queues; q++) begin : g_chk
        // the head of an index FIFO must name a slot the bitmap still holds.
        a_pop_occupied: assert property (@(posedge clk) disable iff (!rst_n)
            pop[q] |-> occupied[head_idx[q]]);
    end

endmodule

/* shared_queue/slot_memory.sv */
module slot_memory (
    input  logic                                                  clk,
    input  shq_types_pkg::queue_vec_t                             wr_en,
    input  shq_types_pkg::slot_idx_t [shq_cfg_pkg::num_queues-1:0] wr_idx,
    input  shq_types_pkg::data_t [shq_cfg_pkg::num_queues-1:0]     wr_data,
    input  shq_types_pkg::slot_idx_t [shq_cfg_pkg::num_queues-1:0] rd_idx,
    output shq_types_pkg::data_t [shq_cfg_pkg::num_queues-1:0]     rd_data
);

    // the pool itself. a slot is only read after it has been written.
    shq_types_pkg::data_t words [shq_cfg_pkg::num_slots];

    // grants never share a slot, so the write ports never collide.
    always_ff @(posedge clk) begin
        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            if (wr_en[q]) begin
                words[wr_idx[q]] <= wr_data[q];
            end
        end
    end

    // each queue reads its head slot without waiting for a clock.
    always_comb begin
        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            rd_data[q] = words[rd_idx[q]];
        end
    end

endmodule

/* verification/shq_tb.sv */
module shq_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period      = 40;
    localparam int single_cycles   = 40;
    localparam int mixed_cycles    = 600;
    localparam int exhaust_cycles  = 300;
    localparam int reuse_cycles    = 200;
    localparam int srst_cycles     = 200;
    localparam int strobe_cycles   = 50;
    localparam int reset_cycles    = 3;
    localparam int watchdog_margin = 50;
    localparam int total_cycles    = reset_cycles + 1
                                   + shq_cfg_pkg::num_queues * single_cycles
                                   + mixed_cycles + exhaust_cycles + reuse_cycles
                                   + srst_cycles + 2 * strobe_cycles;

    logic                                              clk;
    logic                                              rst_n;
    logic                                              softreset;
    shq_types_pkg::queue_vec_t                         vldin;
    shq_types_pkg::data_t [shq_cfg_pkg::num_queues-1:0] din;
    shq_types_pkg::queue_vec_t                         readout;
    shq_types_pkg::data_t [shq_cfg_pkg::num_queues-1:0] dout;
    shq_types_pkg::queue_vec_t                         full;
    shq_types_pkg::queue_vec_t                         empty;
    shq_types_pkg::count_t                             count;

    // expected contents of every queue, head at index 0.
    shq_types_pkg::data_t model_q [shq_cfg_pkg::num_queues][$];

    int errors;
    int checks;
    int tests;

    shared_queue_top u_shared_queue_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .softreset (softreset),
        .vldin     (vldin),
        .din       (din),
        .readout   (readout),
        .dout      (dout),
        .full      (full),
        .empty     (empty),
        .count     (count)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic compare_data(input string name, input shq_types_pkg::data_t exp,
                                input shq_types_pkg::data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_flags(input string name, input shq_types_pkg::queue_vec_t exp,
                                 input shq_types_pkg::queue_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input shq_types_pkg::count_t exp,
                                 input shq_types_pkg::count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // runs at the falling edge, while strobes and outputs are settled.
    // checks the outputs, then moves the model past the next rising edge.
    task automatic check_and_step();
        shq_types_pkg::queue_vec_t exp_full;
        shq_types_pkg::queue_vec_t exp_empty;
        int stored;
        int free_slots;
        stored = 0;
        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            stored += model_q[q].size();
        end
        free_slots = shq_cfg_pkg::num_slots - stored; // reads free nothing this cycle.
        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            exp_empty[q] = (model_q[q].size() == 0);
            exp_full[q]  = (free_slots == 0);
            if (vldin[q] && !exp_full[q]) begin
                free_slots--; // queue q takes a slot ahead of the higher queues.
            end
        end
        compare_flags("full", exp_full, full);
        compare_flags("empty", exp_empty, empty);
        compare_count("count", shq_types_pkg::count_t'(stored), count);
        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            if (!exp_empty[q]) begin
                compare_data($sformatf("dout[%0d]", q), model_q[q][0], dout[q]);
            end
        end
        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            if (softreset) begin
                model_q[q].delete();
            end else begin
                if (readout[q] && !exp_empty[q]) begin
                    void'(model_q[q].pop_front());
                end
                if (vldin[q] && !exp_full[q]) begin
                    model_q[q].push_back(din[q]);
                end
            end
        end
    endtask

    function automatic logic chance(input int pct);
        return int'($urandom % 100) < pct;
    endfunction

    task automatic run_cycles(input int n, input shq_types_pkg::queue_vec_t wr_mask,
                              input int wr_pct, input int rd_pct, input int srst_pct);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
                vldin[q]   <= wr_mask[q] && chance(wr_pct);
                din[q]     <= $urandom;
                readout[q] <= chance(rd_pct);
            end
            softreset <= chance(srst_pct);
            @(negedge clk);
            check_and_step();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int unsigned seed;
        int          start_errors;
        seed = 32'hfd2a995c;
        void'($urandom(seed));
        errors    = 0;
        checks    = 0;
        tests     = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        softreset = 1'b0;
        vldin     = '0;
        din       = '0;
        readout   = '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        start_errors = errors;
        @(negedge clk);
        check_and_step();
        report_test("reset", start_errors);

        for (int q = 0; q < shq_cfg_pkg::num_queues; q++) begin
            start_errors = errors;
            run_cycles(single_cycles, shq_types_pkg::queue_vec_t'(1 << q), 60, 40, 0);
            report_test($sformatf("single_queue_%0d", q), start_errors);
        end

        start_errors = errors;
        run_cycles(mixed_cycles, '1, 50, 50, 1);
        report_test("mixed_traffic", start_errors);

        start_errors = errors;
        run_cycles(exhaust_cycles, '1, 90, 15, 0);
        report_test("pool_exhaustion", start_errors);

        // the pool hovers at full, so freed slots meet new writes often.
        start_errors = errors;
        run_cycles(reuse_cycles, '1, 95, 60, 0);
        report_test("slot_reuse", start_errors);

        start_errors = errors;
        run_cycles(srst_cycles, '1, 70, 20, 8);
        report_test("softreset", start_errors);

        start_errors = errors;
        run_cycles(strobe_cycles, '0, 0, 100, 0);
        run_cycles(strobe_cycles, '1, 100, 0, 0);
        report_test("ignored_strobes", start_errors);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #((total_cycles + watchdog_margin) * clk_period);
        $display("timeout: the tests did not finish in the expected time");
        $display("Errors found");
        $finish;
    end

endmodule
